/* design/bootPkg.sv */
package bootPkg;

	// --------------------------------------------------
	// Vector types.
	// --------------------------------------------------

	// RAM word address, bit 15 picks the half.
	typedef logic [15:0] memAddr_t;

	typedef logic [15:0] memData_t;    // RAM word, also the SPI shift word.
	typedef logic [14:0] sectOffset_t; // Offset within one section.
	typedef logic [3:0]  bitCount_t;   // Bit position in a word or command.
	typedef logic [15:0] flashAddr_t;  // Byte address on the storage chip.

	// --------------------------------------------------
	// Loader FSM.
	// --------------------------------------------------

	// Listed in boot order. The loader steps through them by incrementing,
	// so the order here is the boot sequence itself.
	typedef enum logic [2:0] {
		sStart,    // Load the read command.
		sReadCmd,  // Send 8-bit command.
		sReadAddr, // Send 16-bit start address.
		sTextMeta, // Read text length word.
		sTextData, // Copy text words.
		sDataMeta, // Read data length word.
		sDataData, // Copy data words.
		sDone      // Idle until reset.
	} bootState_t;

	// --------------------------------------------------
	// Storage chip.
	// --------------------------------------------------

	localparam logic [7:0] c_spiReadCmd = 8'h03; // Plain read.

endpackage

/* design/runtimeRam.sv */
module runtimeRam import bootPkg::*; (
	input  logic     i_clk,
	input  logic     i_en,
	input  logic     i_we,
	input  memAddr_t i_addr,
	input  memData_t i_wData,
	output memData_t o_rData
);

	localparam int c_depth = 2 ** $bits(memAddr_t); // 64K words.

	// Lower half text, upper half data.
	memData_t mem [c_depth];

	// Power-up contents are zero.
	initial begin
		for (int i = 0; i < c_depth; i++) begin
			mem[i] = '0;
		end
	end

	// Single port. Reads are registered.
	always_ff @(posedge i_clk) begin
		if (i_en) begin
			if (i_we) begin
				mem[i_addr] <= i_wData;
			end else begin
				o_rData <= mem[i_addr]; // Valid next cycle.
			end
		end
	end

endmodule

/* design/memArbiter.sv */
module memArbiter import bootPkg::*; (
	input  logic     i_clk,
	input  logic     i_reset,

	// Loader. Never stalled.
	input  logic     i_bootWrEn,
	input  memAddr_t i_bootAddr,
	input  memData_t i_bootWData,

	// Host requests.
	input  logic     i_hostValid,
	input  logic     i_hostWrite,
	input  memAddr_t i_hostAddr,
	input  memData_t i_hostWData,
	output logic     o_hostGrant,
	output logic     o_hostRdValid,
	output memData_t o_hostRdData,

	// RAM port.
	output logic     o_ramEn,
	output logic     o_ramWe,
	output memAddr_t o_ramAddr,
	output memData_t o_ramWData,
	input  memData_t i_ramRData
);

	logic hostRdPending; // Host read issued last cycle.

	// --------------------------------------------------
	// Fixed priority select.
	// --------------------------------------------------

	// Loader first. Host gets any cycle without a loader write.
	assign o_hostGrant = i_hostValid && !i_bootWrEn;

	always_comb begin
		if (i_bootWrEn) begin
			o_ramEn    = 1'b1;
			o_ramWe    = 1'b1;
			o_ramAddr  = i_bootAddr;
			o_ramWData = i_bootWData;
		end else begin
			o_ramEn    = i_hostValid;
			o_ramWe    = i_hostValid && i_hostWrite;
			o_ramAddr  = i_hostAddr;
			o_ramWData = i_hostWData;
		end
	end

	// --------------------------------------------------
	// Read return.
	// --------------------------------------------------

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			hostRdPending <= 1'b0;
		end else begin
			hostRdPending <= o_hostGrant && !i_hostWrite;
		end
	end

	assign o_hostRdValid = hostRdPending;
	assign o_hostRdData  = i_ramRData; // RAM has one cycle latency.

endmodule

/* design/apbMemPort.sv */
module apbMemPort import bootPkg::*; (
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_booted,  // Writes allowed once high.

	// APB slave.
	input  logic     i_pSel,
	input  logic     i_pEnable,
	input  logic     i_pWrite,
	input  memAddr_t i_pAddr,
	input  memData_t i_pWData,
	output memData_t o_pRData,
	output logic     o_pReady,
	output logic     o_pSlvErr,

	// Request to the arbiter.
	output logic     o_reqValid,
	output logic     o_reqWrite,
	output memAddr_t o_reqAddr,
	output memData_t o_reqWData,
	input  logic     i_reqGrant,
	input  logic     i_rdValid,
	input  memData_t i_rdData
);

	typedef enum logic [1:0] {
		sIdle,    // Wait for a setup phase.
		sRequest, // Request held until granted.
		sWaitRd,  // Read granted, data next cycle.
		sRespond  // Refused write.
	} apbState_t;

	apbState_t state;
	apbState_t stateNext;

	// --------------------------------------------------
	// Transfer FSM.
	// --------------------------------------------------

	always_comb begin
		stateNext = state;
		case (state)
			sIdle: begin
				if (i_pSel && !i_pEnable) begin // Setup phase.
					// Image still loading? Refuse the write.
					stateNext = (i_pWrite && !i_booted) ? sRespond : sRequest;
				end
			end
			sRequest: begin
				if (i_reqGrant) begin
					stateNext = i_pWrite ? sIdle : sWaitRd;
				end
			end
			sWaitRd: begin
				if (i_rdValid) begin
					stateNext = sIdle;
				end
			end
			default: stateNext = sIdle; // sRespond lasts one cycle.
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= sIdle;
		end else begin
			state <= stateNext;
		end
	end

	// --------------------------------------------------
	// Outputs.
	// --------------------------------------------------

	// APB keeps address and data stable for the whole transfer.
	assign o_reqValid = (state == sRequest);
	assign o_reqWrite = i_pWrite;
	assign o_reqAddr  = i_pAddr;
	assign o_reqWData = i_pWData;

	// Writes finish on the grant, reads when the data comes back.
	assign o_pReady = (state == sRespond)
		|| ((state == sRequest) && i_pWrite && i_reqGrant)
		|| ((state == sWaitRd) && i_rdValid);
	assign o_pSlvErr = (state == sRespond);
	assign o_pRData  = i_rdData;

endmodule

/* design/bootImage.sv */
module bootImage import bootPkg::*; #(
	parameter flashAddr_t p_imageBase = '0 // Image start on the storage chip.
) (
	// Common.
	input  logic      i_clk,
	input  logic      i_reset,

	// Storage chip.
	input  logic      i_spiMiso,
	output logic      o_spiMosi,
	output logic      o_spiEn,

	// Runtime RAM write port.
	output memAddr_t  o_memAddr,
	output memData_t  o_memWrData,
	output logic      o_memWrEn,

	// Boot status.
	output logic      o_booted
);

	// --------------------------------------------------
	// Internal signals.
	// --------------------------------------------------

	bootState_t  state;
	logic        advance;     // Move to the next state.

	bitCount_t   bitCnt;      // Bits sent or received in this state.
	logic        wordEnd;     // 16th bit of a word.

	memData_t    shiftReg;
	memData_t    shiftNext;

	sectOffset_t metaLen;     // Section length minus one.
	sectOffset_t offset;      // Next write offset.
	logic        lastWord;

	logic        memWrEn;
	logic        metaState;
	logic        dataState;
	logic        sectionBit;

	// --------------------------------------------------
	// State decode.
	// --------------------------------------------------

	assign wordEnd   = (bitCnt == 4'd15);
	assign metaState = (state == sTextMeta) || (state == sDataMeta);
	assign dataState = (state == sTextData) || (state == sDataData);
	assign lastWord  = (offset == metaLen);

	// Upper half once the data section starts. The last text write lands
	// in sDataMeta and the last data write in sDone, so both follow.
	assign sectionBit = (state == sDataData) || (state == sDone);

	always_comb begin
		unique case (state)
			sStart:    advance = 1'b1;                // Straight on.
			sReadCmd:  advance = (bitCnt == 4'd7);    // 8 command bits.
			sReadAddr: advance = wordEnd;             // 16 address bits.
			sTextMeta: advance = wordEnd;
			sTextData: advance = wordEnd && lastWord; // Whole section copied.
			sDataMeta: advance = wordEnd;
			sDataData: advance = wordEnd && lastWord;
			default:   advance = 1'b0;                // sDone holds.
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= sStart;
		end else if (advance) begin
			state <= bootState_t'(state + 3'd1);
		end
	end

	// Bit counter restarts with every state.
	always_ff @(posedge i_clk) begin
		if (i_reset || advance) begin
			bitCnt <= '0;
		end else begin
			bitCnt <= bitCnt + 4'd1;
		end
	end

	// --------------------------------------------------
	// SPI shift register.
	// --------------------------------------------------

	assign shiftNext = {shiftReg[14:0], i_spiMiso}; // MSB first.

	always_ff @(posedge i_clk) begin
		if (state == sStart) begin
			shiftReg <= {c_spiReadCmd, 8'h00}; // Command in the top byte.
		end else begin
			shiftReg <= shiftNext;
		end
	end

	// Length field of the metadata word.
	always_ff @(posedge i_clk) begin
		if (metaState && wordEnd) begin
			metaLen <= shiftNext[14:0]; // Top bit unused.
		end
	end

	// --------------------------------------------------
	// RAM writes.
	// --------------------------------------------------

	// Pulse the cycle after a data word completes.
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			memWrEn <= 1'b0;
		end else begin
			memWrEn <= dataState && wordEnd;
		end
	end

	// Clear wins. A write pulse in the first metadata cycle still
	// sees the old offset.
	always_ff @(posedge i_clk) begin
		if (i_reset || metaState) begin
			offset <= '0;
		end else if (memWrEn) begin
			offset <= offset + 15'd1;
		end
	end

	// --------------------------------------------------
	// Outputs.
	// --------------------------------------------------

	always_comb begin
		case (state)
			sReadCmd:  o_spiMosi = shiftReg[15];
			sReadAddr: o_spiMosi = p_imageBase[4'd15 - bitCnt]; // MSB first.
			default:   o_spiMosi = 1'b0;
		endcase
	end

	assign o_spiEn     = (state != sStart) && (state != sDone);
	assign o_memAddr   = {sectionBit, offset};
	assign o_memWrData = shiftReg; // Full word during the pulse.
	assign o_memWrEn   = memWrEn;

	// Wait out the final write.
	assign o_booted = (state == sDone) && !memWrEn;

endmodule

/* design/bootSystem.sv */
module bootSystem import bootPkg::*; #(
	parameter flashAddr_t p_imageBase = '0
) (
	input  logic     i_clk,
	input  logic     i_reset,

	// Storage chip.
	input  logic     i_spiMiso,
	output logic     o_spiMosi,
	output logic     o_spiEn,

	// APB host port.
	input  logic     i_pSel,
	input  logic     i_pEnable,
	input  logic     i_pWrite,
	input  memAddr_t i_pAddr,
	input  memData_t i_pWData,
	output memData_t o_pRData,
	output logic     o_pReady,
	output logic     o_pSlvErr,

	output logic     o_booted
);

	// Loader to arbiter.
	logic     bootWrEn;
	memAddr_t bootAddr;
	memData_t bootWData;
	logic     booted;

	// APB port to arbiter.
	logic     reqValid;
	logic     reqWrite;
	memAddr_t reqAddr;
	memData_t reqWData;
	logic     reqGrant;
	logic     rdValid;
	memData_t rdData;

	// Arbiter to RAM.
	logic     ramEn;
	logic     ramWe;
	memAddr_t ramAddr;
	memData_t ramWData;
	memData_t ramRData;

	// --------------------------------------------------
	// Blocks.
	// --------------------------------------------------

	bootImage #(
		.p_imageBase(p_imageBase)
	) loader_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_spiMiso(i_spiMiso),
		.o_spiMosi(o_spiMosi),
		.o_spiEn(o_spiEn),
		.o_memAddr(bootAddr),
		.o_memWrData(bootWData),
		.o_memWrEn(bootWrEn),
		.o_booted(booted)
	);

	apbMemPort apbPort_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_booted(booted), // Gates host writes.
		.i_pSel(i_pSel),
		.i_pEnable(i_pEnable),
		.i_pWrite(i_pWrite),
		.i_pAddr(i_pAddr),
		.i_pWData(i_pWData),
		.o_pRData(o_pRData),
		.o_pReady(o_pReady),
		.o_pSlvErr(o_pSlvErr),
		.o_reqValid(reqValid),
		.o_reqWrite(reqWrite),
		.o_reqAddr(reqAddr),
		.o_reqWData(reqWData),
		.i_reqGrant(reqGrant),
		.i_rdValid(rdValid),
		.i_rdData(rdData)
	);

	memArbiter arbiter_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_bootWrEn(bootWrEn),
		.i_bootAddr(bootAddr),
		.i_bootWData(bootWData),
		.i_hostValid(reqValid),
		.i_hostWrite(reqWrite),
		.i_hostAddr(reqAddr),
		.i_hostWData(reqWData),
		.o_hostGrant(reqGrant),
		.o_hostRdValid(rdValid),
		.o_hostRdData(rdData),
		.o_ramEn(ramEn),
		.o_ramWe(ramWe),
		.o_ramAddr(ramAddr),
		.o_ramWData(ramWData),
		.i_ramRData(ramRData)
	);

	runtimeRam ram_i (
		.i_clk(i_clk),
		.i_en(ramEn),
		.i_we(ramWe),
		.i_addr(ramAddr),
		.i_wData(ramWData),
		.o_rData(ramRData)
	);

	assign o_booted = booted;

endmodule

/* test/spiFlashModel.sv */
module spiFlashModel import bootPkg::*; (
	input  logic        i_clk,
	input  logic        i_spiEn,
	input  logic        i_spiMosi,
	output logic        o_spiMiso,
	output logic [23:0] o_cmdBits  // Command and address as received.
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] flashMem [65536]; // Loaded by the testbench.
	int         bitPos = 0;       // Bits since enable went high.
	int         imageBit;         // Bit index into the image.
	flashAddr_t byteAddr;

	initial begin
		o_cmdBits = '0;
		o_spiMiso = 1'b0;
	end

	// --------------------------------------------------
	// Command decode and data shift-out.
	// --------------------------------------------------

	// First image bit goes out right after the last address bit.
	always @(posedge i_clk) begin
		if (i_spiEn === 1'b1) begin
			if (bitPos < 24) begin
				o_cmdBits[23 - bitPos] = i_spiMosi; // MSB first.
			end
			bitPos = bitPos + 1;
			// Only a read command gets data back.
			if (bitPos >= 24 && o_cmdBits[23:16] == c_spiReadCmd) begin
				imageBit = bitPos - 24;
				byteAddr = o_cmdBits[15:0] + flashAddr_t'(imageBit / 8);
				o_spiMiso <= flashMem[byteAddr][7 - imageBit % 8];
			end else begin
				o_spiMiso <= 1'b0;
			end
		end else begin
			bitPos = 0;
			o_spiMiso <= 1'b0; // Idle low.
		end
	end

endmodule

/* test/bootSystemTb.sv */
module bootSystemTb import bootPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam flashAddr_t c_imageBase = 16'h2c40; // Nonzero image start.
	localparam logic [7:0] c_readCmd = 8'h03;
	localparam int         c_period = 40;
	localparam int         c_nTargets = 4;        // Addresses hit during boot.
	localparam int         c_nRandom = 16;        // Random writes after boot.

	logic        clk;
	logic        rst;
	logic        spiMiso;
	logic        spiMosi;
	logic        spiEn;
	logic        pSel;
	logic        pEnable;
	logic        pWrite;
	memAddr_t    pAddr;
	memData_t    pWData;
	memData_t    pRData;
	logic        pReady;
	logic        pSlvErr;
	logic        booted;
	logic [23:0] cmdBits;

	int       errors = 0;
	int       checks = 0;
	int       textLen;
	int       dataLen;
	int       bootBound;                // Cycles from reset to o_booted.
	int       limitCycles;
	logic     limitReady = 1'b0;
	int       accessCycles;             // Of the last APB transfer.
	int       bootCycles = 0;
	logic     bootSeen = 1'b0;
	memData_t image [$];                // Words in stream order.
	memData_t ramModel [memAddr_t];
	memAddr_t targets [c_nTargets];
	memAddr_t wrAddrs [$];

	bootSystem #(
		.p_imageBase(c_imageBase)
	) dut_i (
		.i_clk(clk),
		.i_reset(rst),
		.i_spiMiso(spiMiso),
		.o_spiMosi(spiMosi),
		.o_spiEn(spiEn),
		.i_pSel(pSel),
		.i_pEnable(pEnable),
		.i_pWrite(pWrite),
		.i_pAddr(pAddr),
		.i_pWData(pWData),
		.o_pRData(pRData),
		.o_pReady(pReady),
		.o_pSlvErr(pSlvErr),
		.o_booted(booted)
	);

	spiFlashModel flash_i (
		.i_clk(clk),
		.i_spiEn(spiEn),
		.i_spiMosi(spiMosi),
		.o_spiMiso(spiMiso),
		.o_cmdBits(cmdBits)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(c_period / 2) clk = ~clk;
		end
	end

	initial begin
		wait (limitReady);
		#(limitCycles * c_period);
		$display("Watchdog expired after %0d cycles", limitCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// --------------------------------------------------
	// APB driver and checks.
	// --------------------------------------------------

	// Starts 2 ns after an edge and ends 2 ns after the PREADY edge.
	task automatic apbTransfer(input logic write, input memAddr_t addr, input memData_t wdata,
		output memData_t rdata, output logic slvErr);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = wdata;
		@(posedge clk);
		#2 pEnable = 1'b1; // Access phase.
		accessCycles = 0;
		do begin
			@(posedge clk);
			accessCycles++;
		end while (!pReady && accessCycles < 20);
		rdata = pRData;
		slvErr = pSlvErr;
		if (!pReady) begin
			errors++;
			$display("APB transfer at %h got no PREADY within 20 cycles", addr);
		end
		#2;
		pSel = 1'b0;
		pEnable = 1'b0;
	endtask

	// Model contents, zero where nothing was ever written.
	function automatic memData_t modelWord(input memAddr_t addr);
		return ramModel.exists(addr) ? ramModel[addr] : 16'h0000;
	endfunction

	task automatic checkSlvErr(input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error o_pSlvErr: got %h expected %h", got, expected);
		end
	endtask

	task automatic readCheck(input memAddr_t addr);
		memData_t rdata;
		memData_t expected;
		logic     slvErr;
		expected = modelWord(addr);
		apbTransfer(1'b0, addr, '0, rdata, slvErr);
		checkSlvErr(slvErr, 1'b0);
		checks++;
		if (rdata !== expected) begin
			errors++;
			$display("error o_pRData: addr %h got %h expected %h", addr, rdata, expected);
		end
	endtask

	// Boot must finish in time, then o_booted holds and SPI stays off.
	always @(posedge clk) begin
		if (!rst) begin
			if (bootSeen) begin
				if (booted !== 1'b1) begin
					errors++;
					$display("error o_booted: got %h expected 1", booted);
				end
				if (spiEn !== 1'b0) begin
					errors++;
					$display("error o_spiEn: got %h expected 0", spiEn);
				end
			end else if (booted) begin
				bootSeen = 1'b1;
			end else begin
				bootCycles++;
				if (bootCycles == bootBound + 1) begin
					errors++;
					$display("o_booted did not rise within %0d cycles", bootBound);
				end
			end
		end
	end

	// --------------------------------------------------
	// Main sequence.
	// --------------------------------------------------

	initial begin
		memAddr_t addr;
		memData_t word;
		memData_t rdata;
		logic     slvErr;
		int       idx;
		int       transfers;

		void'($urandom(45221));
		rst = 1'b1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;

		for (int a = 0; a < 65536; a++) begin
			flash_i.flashMem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a; // Background.
		end
		// Image is metadata, text, metadata, data. Top metadata bit is junk.
		textLen = 1 + $urandom % 40;
		dataLen = 1 + $urandom % 40;
		image.push_back({1'($urandom), 15'(textLen - 1)});
		for (int i = 0; i < textLen; i++) begin
			word = 16'($urandom);
			image.push_back(word);
			ramModel[memAddr_t'(i)] = word; // Lower half.
		end
		image.push_back({1'($urandom), 15'(dataLen - 1)});
		for (int i = 0; i < dataLen; i++) begin
			word = 16'($urandom);
			image.push_back(word);
			ramModel[16'h8000 | memAddr_t'(i)] = word; // Upper half.
		end
		foreach (image[k]) begin
			flash_i.flashMem[16'(c_imageBase + 2 * k)] = image[k][15:8]; // Big endian.
			flash_i.flashMem[16'(c_imageBase + 2 * k + 1)] = image[k][7:0];
		end

		// Final write, plus the reset and sampling edges.
		bootBound = 57 + 16 * (textLen + dataLen) + 1 + 2;
		transfers = 3 * c_nTargets + bootBound / 3 + 1 + textLen + dataLen + 2
			+ 2 * c_nRandom;
		limitCycles = 2 * (bootBound + 20 * transfers);
		limitReady = 1'b1;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		// Nothing copied yet, so every target still reads zero.
		for (int i = 0; i < c_nTargets; i++) begin
			if (i % 2 == 0) begin
				targets[i] = memAddr_t'($urandom % textLen);
			end else begin
				targets[i] = 16'h8000 | memAddr_t'($urandom % dataLen);
			end
			apbTransfer(1'b0, targets[i], '0, rdata, slvErr);
			checkSlvErr(slvErr, 1'b0);
			checks++;
			if (rdata !== 16'h0000) begin
				errors++;
				$display("error o_pRData: addr %h got %h expected %h", targets[i], rdata,
					16'h0000);
			end
		end

		// Writes while loading must bounce.
		for (int i = 0; i < c_nTargets; i++) begin
			apbTransfer(1'b1, targets[i], ~ramModel[targets[i]], rdata, slvErr);
			checkSlvErr(slvErr, 1'b1);
			if (accessCycles != 1) begin
				errors++;
				$display("Refused write took %0d access cycles instead of 1", accessCycles);
			end
		end

		// Reads racing the copy. Old or new word, never anything else.
		idx = 0;
		while (!booted) begin
			addr = targets[idx % c_nTargets];
			apbTransfer(1'b0, addr, '0, rdata, slvErr);
			checkSlvErr(slvErr, 1'b0);
			checks++;
			if (rdata !== 16'h0000 && rdata !== modelWord(addr)) begin
				errors++;
				$display("error o_pRData: addr %h got %h expected %h or %h", addr, rdata,
					16'h0000, modelWord(addr));
			end
			idx++;
		end

		checks++;
		if (cmdBits !== {c_readCmd, c_imageBase}) begin
			errors++;
			$display("error o_spiMosi: got %h expected %h", cmdBits, {c_readCmd, c_imageBase});
		end

		// Whole image, plus one word past each section.
		for (int i = 0; i <= textLen; i++) begin
			readCheck(memAddr_t'(i));
		end
		for (int i = 0; i <= dataLen; i++) begin
			readCheck(16'h8000 | memAddr_t'(i));
		end
		for (int i = 0; i < c_nTargets; i++) begin
			readCheck(targets[i]); // Image word, not the refused data.
		end

		// Host owns the RAM now.
		for (int i = 0; i < c_nRandom; i++) begin
			addr = 16'($urandom);
			word = 16'($urandom);
			apbTransfer(1'b1, addr, word, rdata, slvErr);
			checkSlvErr(slvErr, 1'b0);
			ramModel[addr] = word;
			wrAddrs.push_back(addr);
		end
		for (int i = 0; i < c_nRandom; i++) begin
			readCheck(wrAddrs[$urandom % wrAddrs.size()]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* bootSystem.f */
design/bootPkg.sv
design/runtimeRam.sv
design/memArbiter.sv
design/apbMemPort.sv
design/bootImage.sv
design/bootSystem.sv
test/spiFlashModel.sv
test/bootSystemTb.sv
